// ==== list.f ====
common/int_exec_pkg.sv
int_rs/int_rs.sv
design/phys_reg_file.sv
design/fu_alu.sv
design/int_exec_top.sv
verification/tb_clock_gen.sv
verification/int_exec_tb.sv

// ==== verification/int_exec_tb.sv ====
`timescale 1ns/1ps

module int_exec_tb
    import int_exec_pkg::*;
();

    localparam int WAIT_LIMIT = 100;
    localparam int ROB_COUNT  = 1 << ROB_IDX;

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    uop_t disp_uop;
    cdb_t ext_wb;
    cdb_t cdb_alu;

    // scoreboard indexed by rob_id
    logic [XLEN-1:0]    shadow [PHY_REGS];
    uop_t               uop_tab [ROB_COUNT];
    int                 issued_cnt [ROB_COUNT];
    int                 done_cnt [ROB_COUNT];
    int                 done_seq [ROB_COUNT];
    logic               waiting [ROB_COUNT];
    logic [PHY_IDX-1:0] wait_phy [ROB_COUNT];
    int                 seq;
    uop_t               cur_uop;
    logic [XLEN-1:0]    exp_value;
    logic               rob_pending;
    logic               rob_waiting;

    string              test_name;
    int                 err_count;
    int                 test_errs;
    int                 pass_count;
    int                 fail_count;
    logic [ROB_IDX-1:0] next_rob;

    tb_clock_gen i_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    int_exec_top i_int_exec_top (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_uop   (disp_uop),
        .ext_wb     (ext_wb),
        .cdb_alu    (cdb_alu)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] expected_result(input uop_t u,
                                                        input logic [XLEN-1:0] r1,
                                                        input logic [XLEN-1:0] r2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        int              sh;
        case (u.op1_sel)
            op1_rs1: a = r1;
            op1_pc:  a = u.pc;
            default: a = '0;
        endcase
        case (u.op2_sel)
            op2_rs2: b = r2;
            op2_imm: b = u.imm;
            default: b = '0;
        endcase
        sh = int'(b[4:0]);
        case (u.fu_opcode)
            alu_add:  r = a + b;
            alu_sub:  r = a + ~b + 1;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_sll:  r = a << sh;
            alu_srl:  r = a >> sh;
            // logical shift, then fill the vacated top bits with the sign
            alu_sra:  r = (a >> sh) | (~({XLEN{1'b1}} >> sh) & {XLEN{a[XLEN-1]}});
            alu_slt:  r = (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
            alu_sltu: r = XLEN'(a < b);
            default:  r = '0;
        endcase
        return r;
    endfunction

    assign cur_uop     = uop_tab[cdb_alu.rob_id];
    assign rob_pending = issued_cnt[cdb_alu.rob_id] > done_cnt[cdb_alu.rob_id];
    assign rob_waiting = waiting[cdb_alu.rob_id];

    always_comb begin
        exp_value = expected_result(cur_uop, shadow[cur_uop.rs1_phy], shadow[cur_uop.rs2_phy]);
    end

    // shadow registers and completion record
    always @(posedge clk) begin
        if (rst) begin
            seq <= 0;
            for (int i = 0; i < PHY_REGS; i++) begin
                shadow[i] <= '0;
            end
            for (int r = 0; r < ROB_COUNT; r++) begin
                done_cnt[r] <= 0;
                done_seq[r] <= 0;
            end
        end else begin
            if (cdb_alu.valid) begin
                shadow[cdb_alu.rd_phy]   <= cdb_alu.value;
                done_cnt[cdb_alu.rob_id] <= done_cnt[cdb_alu.rob_id] + 1;
                done_seq[cdb_alu.rob_id] <= seq;
                seq                      <= seq + 1;
            end
            // lane 1 last, so it wins a collision
            if (ext_wb.valid) begin
                shadow[ext_wb.rd_phy] <= ext_wb.value;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    reset_state_check: assert property (@(posedge clk) $fell(rst) |-> (disp_ready && !cdb_alu.valid))
        else begin
            $display("%s: disp_ready low or a result on lane 0 right after reset", test_name);
            note_error();
        end

    result_value_check: assert property (@(posedge clk) disable iff (rst)
        cdb_alu.valid |-> (cdb_alu.value == exp_value))
        else begin
            $display("error %s: rob_id %0d expected %h actual %h", test_name,
                     $sampled(cdb_alu.rob_id), $sampled(exp_value), $sampled(cdb_alu.value));
            note_error();
        end

    result_dest_check: assert property (@(posedge clk) disable iff (rst)
        cdb_alu.valid |-> (cdb_alu.rd_phy == cur_uop.rd_phy))
        else begin
            $display("error %s: rob_id %0d rd_phy expected %0d actual %0d", test_name,
                     $sampled(cdb_alu.rob_id), $sampled(cur_uop.rd_phy),
                     $sampled(cdb_alu.rd_phy));
            note_error();
        end

    // also catches a second result for the same micro-op
    result_owner_check: assert property (@(posedge clk) disable iff (rst)
        cdb_alu.valid |-> rob_pending)
        else begin
            $display("%s: result for rob_id %0d with no micro-op outstanding", test_name,
                     $sampled(cdb_alu.rob_id));
            note_error();
        end

    wakeup_check: assert property (@(posedge clk) disable iff (rst)
        cdb_alu.valid |-> !rob_waiting)
        else begin
            $display("%s: rob_id %0d completed before its source was broadcast", test_name,
                     $sampled(cdb_alu.rob_id));
            note_error();
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic note_error();
        err_count++;
    endtask

    function automatic uop_t make_uop(input fu_opcode_t op, input op1_sel_t s1,
                                      input op2_sel_t s2, input logic [PHY_IDX-1:0] rs1,
                                      input logic [PHY_IDX-1:0] rs2,
                                      input logic [PHY_IDX-1:0] rd);
        uop_t u;
        u.rob_id    = '0;
        u.rd_phy    = rd;
        // unused sources point at a register nobody writes
        u.rs1_valid = (s1 == op1_rs1);
        u.rs1_phy   = u.rs1_valid ? rs1 : PHY_IDX'(PHY_REGS - 1);
        u.rs2_valid = (s2 == op2_rs2);
        u.rs2_phy   = u.rs2_valid ? rs2 : PHY_IDX'(PHY_REGS - 1);
        u.op1_sel   = s1;
        u.op2_sel   = s2;
        u.fu_opcode = op;
        u.imm       = $urandom;
        u.pc        = $urandom;
        return u;
    endfunction

    task automatic write_reg(input logic [PHY_IDX-1:0] phy, input logic [XLEN-1:0] value);
        ext_wb.valid  = 1'b1;
        ext_wb.rob_id = '0;
        ext_wb.rd_phy = phy;
        ext_wb.value  = value;
        @(posedge clk);
        #1;
        ext_wb.valid = 1'b0;
        // a result may show up from the cycle after the broadcast on
        for (int r = 0; r < ROB_COUNT; r++) begin
            if (waiting[r] && (wait_phy[r] == phy)) begin
                waiting[r] = 1'b0;
            end
        end
    endtask

    task automatic record_uop(inout uop_t u, input logic must_wait);
        u.rob_id          = next_rob;
        next_rob          = next_rob + 1'b1;
        uop_tab[u.rob_id] = u;
        waiting[u.rob_id] = must_wait;
        wait_phy[u.rob_id] = u.rs1_phy;
        issued_cnt[u.rob_id]++;
    endtask

    // holds the micro-op on the port until the station takes it
    task automatic send_uop(input uop_t u);
        int cycles;
        cycles     = 0;
        disp_uop   = u;
        disp_valid = 1'b1;
        while (!disp_ready && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!disp_ready) begin
            $display("%s: dispatch of rob_id %0d never accepted", test_name, u.rob_id);
            note_error();
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic dispatch(inout uop_t u, input logic must_wait);
        record_uop(u, must_wait);
        send_uop(u);
    endtask

    task automatic wait_result(input logic [ROB_IDX-1:0] rob);
        int cycles;
        cycles = 0;
        while ((done_cnt[rob] < issued_cnt[rob]) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (done_cnt[rob] < issued_cnt[rob]) begin
            $display("%s: timed out waiting for the result of rob_id %0d", test_name, rob);
            note_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        @(posedge clk);
        #1;
        if (err_count == test_errs) begin
            pass_count++;
            $display("test %s: pass", test_name);
        end else begin
            fail_count++;
            $display("test %s: FAIL, %0d errors", test_name, err_count - test_errs);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        uop_t               u;
        logic [XLEN-1:0]    acc;
        logic [ROB_IDX-1:0] robs [INTRS_DEPTH + 1];
        int                 cycles;

        void'($urandom(32'hcab7_eb60));
        disp_valid = 1'b0;
        disp_uop   = '0;
        ext_wb     = '0;
        next_rob   = '0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        for (int r = 0; r < ROB_COUNT; r++) begin
            uop_tab[r]    = '0;
            issued_cnt[r] = 0;
            waiting[r]    = 1'b0;
            wait_phy[r]   = '0;
        end

        begin_test("reset_state");
        cycles = 0;
        while ((rst !== 1'b0) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset_state: reset was never released");
            note_error();
        end
        #1;

        repeat (3) begin
            @(posedge clk);
            #1;
            assert (disp_ready && !cdb_alu.valid)
                else begin
                    $display("reset_state: station not idle after reset");
                    note_error();
                end
        end
        end_test();

        // every opcode against every operand select
        begin_test("arithmetic");
        for (int k = 0; k < 10; k++) begin
            for (int s1 = 0; s1 < 3; s1++) begin
                for (int s2 = 0; s2 < 3; s2++) begin
                    write_reg(6'd10, $urandom);
                    write_reg(6'd11, $urandom);
                    u = make_uop(fu_opcode_t'(k), op1_sel_t'(s1), op2_sel_t'(s2),
                                 6'd10, 6'd11, 6'd12);
                    dispatch(u, 1'b0);
                    wait_result(u.rob_id);
                end
            end
        end
        end_test();

        begin_test("wakeup");
        u = make_uop(alu_add, op1_rs1, op2_imm, 6'd20, 6'd0, 6'd21);
        u.rs1_valid = 1'b0;
        dispatch(u, 1'b1);
        repeat (5) @(posedge clk);
        #1;
        write_reg(6'd20, $urandom);
        wait_result(u.rob_id);
        end_test();

        // each link wakes on the previous result on lane 0
        begin_test("chaining");
        write_reg(6'd30, $urandom);
        acc = shadow[30];
        for (int k = 0; k < 6; k++) begin
            u = make_uop(fu_opcode_t'(k % 5), op1_rs1, op2_imm, PHY_IDX'(30 + k), 6'd0,
                         PHY_IDX'(31 + k));
            if (k > 0) begin
                u.rs1_valid = 1'b0;
            end
            acc = expected_result(u, acc, '0);
            dispatch(u, 1'b0);
        end
        wait_result(u.rob_id);
        assert (shadow[36] == acc)
            else begin
                $display("error chaining: expected %h actual %h", acc, shadow[36]);
                note_error();
            end
        end_test();

        begin_test("full_station");
        for (int k = 0; k < INTRS_DEPTH; k++) begin
            u = make_uop(alu_add, op1_rs1, op2_imm, 6'd40, 6'd0, PHY_IDX'(41 + k));
            u.rs1_valid = 1'b0;
            dispatch(u, 1'b1);
            robs[k] = u.rob_id;
        end
        assert (!disp_ready)
            else begin
                $display("full_station: disp_ready still high with every entry held");
                note_error();
            end
        u = make_uop(alu_or, op1_zero, op2_imm, 6'd0, 6'd0, 6'd49);
        record_uop(u, 1'b0);
        robs[INTRS_DEPTH] = u.rob_id;
        disp_uop   = u;
        disp_valid = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!disp_ready && (done_cnt[u.rob_id] < issued_cnt[u.rob_id]))
                else begin
                    $display("full_station: ninth micro-op was not held back");
                    note_error();
                end
        end
        write_reg(6'd40, $urandom);
        send_uop(u);
        for (int k = 0; k <= INTRS_DEPTH; k++) begin
            wait_result(robs[k]);
        end
        end_test();

        // older micro-op stalls on r50, younger one is ready
        begin_test("out_of_order");
        u = make_uop(alu_add, op1_rs1, op2_imm, 6'd50, 6'd0, 6'd51);
        u.rs1_valid = 1'b0;
        dispatch(u, 1'b1);
        robs[0] = u.rob_id;
        u = make_uop(alu_xor, op1_pc, op2_imm, 6'd0, 6'd0, 6'd52);
        dispatch(u, 1'b0);
        robs[1] = u.rob_id;
        wait_result(robs[1]);
        write_reg(6'd50, $urandom);
        wait_result(robs[0]);
        assert (done_seq[robs[1]] < done_seq[robs[0]])
            else begin
                $display("out_of_order: younger rob_id %0d did not complete first", robs[1]);
                note_error();
            end
        end_test();

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for four rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== design/int_exec_top.sv ====
`timescale 1ns/1ps

module int_exec_top
    import int_exec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic disp_valid,
    output logic disp_ready,
    input  uop_t disp_uop,
    input  cdb_t ext_wb,
    output cdb_t cdb_alu
);

    // broadcast lanes, alu first
    cdb_t cdb_lanes [CDB_WIDTH];

    logic [PHY_IDX-1:0] rs1_phy;
    logic [PHY_IDX-1:0] rs2_phy;
    logic [XLEN-1:0]    rs1_value;
    logic [XLEN-1:0]    rs2_value;
    logic               issue_valid;
    alu_issue_t         issue;

    assign cdb_lanes[0] = cdb_alu;
    assign cdb_lanes[1] = ext_wb;

    //////////////////////////////////////////////////////////////////////
    // station, register file, alu
    //////////////////////////////////////////////////////////////////////

    int_rs i_int_rs (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp_uop    (disp_uop),
        .cdb         (cdb_lanes),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    phys_reg_file i_phys_reg_file (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb_lanes),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_alu i_fu_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb_alu     (cdb_alu)
    );

endmodule

// ==== design/fu_alu.sv ====
`timescale 1ns/1ps

module fu_alu
    import int_exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  alu_issue_t issue,
    output cdb_t       cdb_alu
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////
    // operand select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.op1_sel)
            op1_rs1: op1 = issue.rs1_value;
            op1_pc:  op1 = issue.pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (issue.op2_sel)
            op2_rs2: op2 = issue.rs2_value;
            op2_imm: op2 = issue.imm;
            default: op2 = '0;
        endcase
    end

    // shift amount from low bits only
    assign shamt = op2[4:0];

    //////////////////////////////////////////////////////////////////////
    // compute
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.fu_opcode)
            alu_add:  result = op1 + op2;
            alu_sub:  result = op1 - op2;
            alu_and:  result = op1 & op2;
            alu_or:   result = op1 | op2;
            alu_xor:  result = op1 ^ op2;
            alu_sll:  result = op1 << shamt;
            alu_srl:  result = op1 >> shamt;
            alu_sra:  result = XLEN'($signed(op1) >>> shamt);
            alu_slt:  result = XLEN'($signed(op1) < $signed(op2));
            alu_sltu: result = XLEN'(op1 < op2);
            default:  result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // writeback register onto lane 0
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_alu.valid <= 1'b0;
        end else begin
            cdb_alu.valid <= issue_valid;
        end
        // payload only moves on an issue
        if (issue_valid) begin
            cdb_alu.rob_id <= issue.rob_id;
            cdb_alu.rd_phy <= issue.rd_phy;
            cdb_alu.value  <= result;
        end
    end

endmodule

// ==== design/phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file
    import int_exec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  cdb_t                cdb [CDB_WIDTH],
    input  logic [PHY_IDX-1:0]  rs1_phy,
    input  logic [PHY_IDX-1:0]  rs2_phy,
    output logic [XLEN-1:0]     rs1_value,
    output logic [XLEN-1:0]     rs2_value
);

    logic [XLEN-1:0] regs [PHY_REGS];

    //////////////////////////////////////////////////////////////////////
    // write from both lanes
    //////////////////////////////////////////////////////////////////////

    // later lane overrides, so lane 1 wins a collision
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb[k].valid) begin
                    regs[cdb[k].rd_phy] <= cdb[k].value;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read with same-cycle forwarding
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rs1_value = regs[rs1_phy];
        rs2_value = regs[rs2_phy];
        // same lane priority as the write
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb[k].valid && (cdb[k].rd_phy == rs1_phy)) begin
                rs1_value = cdb[k].value;
            end
            if (cdb[k].valid && (cdb[k].rd_phy == rs2_phy)) begin
                rs2_value = cdb[k].value;
            end
        end
    end

endmodule

// ==== int_rs/int_rs.sv ====
`timescale 1ns/1ps

module int_rs
    import int_exec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                disp_valid,
    output logic                disp_ready,
    input  uop_t                disp_uop,
    input  cdb_t                cdb [CDB_WIDTH],
    output logic [PHY_IDX-1:0]  rs1_phy,
    output logic [PHY_IDX-1:0]  rs2_phy,
    input  logic [XLEN-1:0]     rs1_value,
    input  logic [XLEN-1:0]     rs2_value,
    output logic                issue_valid,
    output alu_issue_t          issue
);

    // entry storage, free bit per slot
    uop_t                   entries [INTRS_DEPTH];
    logic [INTRS_DEPTH-1:0] entry_free;

    logic                   push_en;
    logic [INTRS_IDX-1:0]   push_idx;
    logic                   pop_en;
    logic [INTRS_IDX-1:0]   pop_idx;

    // this cycle's broadcast hits
    logic [INTRS_DEPTH-1:0] rs1_hit;
    logic [INTRS_DEPTH-1:0] rs2_hit;
    logic                   disp_rs1_hit;
    logic                   disp_rs2_hit;

    logic [INTRS_DEPTH-1:0] src1_rdy;
    logic [INTRS_DEPTH-1:0] src2_rdy;
    logic [INTRS_DEPTH-1:0] entry_ready;

    // any valid lane writing this physical register
    function automatic logic lane_hit(input cdb_t lanes [CDB_WIDTH],
                                      input logic [PHY_IDX-1:0] phy);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (lanes[k].valid && (lanes[k].rd_phy == phy)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // wakeup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            rs1_hit[i] = lane_hit(cdb, entries[i].rs1_phy);
            rs2_hit[i] = lane_hit(cdb, entries[i].rs2_phy);
        end
    end

    // incoming uop can miss a broadcast in its dispatch cycle
    assign disp_rs1_hit = lane_hit(cdb, disp_uop.rs1_phy);
    assign disp_rs2_hit = lane_hit(cdb, disp_uop.rs2_phy);

    // pc, imm and zero selects need no register
    always_comb begin
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            src1_rdy[i]    = (entries[i].op1_sel != op1_rs1) || entries[i].rs1_valid
                             || rs1_hit[i];
            src2_rdy[i]    = (entries[i].op2_sel != op2_rs2) || entries[i].rs2_valid
                             || rs2_hit[i];
            entry_ready[i] = !entry_free[i] && src1_rdy[i] && src2_rdy[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // allocate and select
    //////////////////////////////////////////////////////////////////////

    assign disp_ready = |entry_free;
    assign push_en    = disp_valid && disp_ready;

    // lowest free slot, scanned downwards so the lowest wins
    always_comb begin
        push_idx = '0;
        for (int i = INTRS_DEPTH - 1; i >= 0; i--) begin
            if (entry_free[i]) begin
                push_idx = INTRS_IDX'(i);
            end
        end
    end

    // lowest ready slot
    always_comb begin
        pop_en  = 1'b0;
        pop_idx = '0;
        for (int i = INTRS_DEPTH - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                pop_en  = 1'b1;
                pop_idx = INTRS_IDX'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_free <= '1;
        end else begin
            if (push_en) begin
                entry_free[push_idx] <= 1'b0;
            end
            if (pop_en) begin
                entry_free[pop_idx] <= 1'b1;
            end
        end
    end

    // push, then snoop the held entries
    always_ff @(posedge clk) begin
        if (push_en) begin
            entries[push_idx]           <= disp_uop;
            entries[push_idx].rs1_valid <= disp_uop.rs1_valid | disp_rs1_hit;
            entries[push_idx].rs2_valid <= disp_uop.rs2_valid | disp_rs2_hit;
        end
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            if (!entry_free[i]) begin
                if (rs1_hit[i]) begin
                    entries[i].rs1_valid <= 1'b1;
                end
                if (rs2_hit[i]) begin
                    entries[i].rs2_valid <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register read and issue
    //////////////////////////////////////////////////////////////////////

    assign rs1_phy     = entries[pop_idx].rs1_phy;
    assign rs2_phy     = entries[pop_idx].rs2_phy;
    assign issue_valid = pop_en;

    always_comb begin
        issue.rob_id    = entries[pop_idx].rob_id;
        issue.rd_phy    = entries[pop_idx].rd_phy;
        issue.op1_sel   = entries[pop_idx].op1_sel;
        issue.op2_sel   = entries[pop_idx].op2_sel;
        issue.fu_opcode = entries[pop_idx].fu_opcode;
        issue.imm       = entries[pop_idx].imm;
        issue.pc        = entries[pop_idx].pc;
        // forwarded by the register file when broadcast this cycle
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

// ==== common/int_exec_pkg.sv ====
package int_exec_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int PHY_REGS    = 64;
    localparam int PHY_IDX     = 6;
    localparam int INTRS_DEPTH = 8;
    localparam int INTRS_IDX   = 3;
    localparam int ROB_IDX     = 5;

    // lane 0 is the alu, lane 1 is external writeback
    localparam int CDB_WIDTH   = 2;

    //////////////////////////////////////////////////////////////////////
    // operand selects and opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op1_rs1  = 2'b00,
        op1_pc   = 2'b01,
        op1_zero = 2'b10
    } op1_sel_t;

    typedef enum logic [1:0] {
        op2_rs2  = 2'b00,
        op2_imm  = 2'b01,
        op2_zero = 2'b10
    } op2_sel_t;

    // and, or, xor are keywords, hence the prefix
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } fu_opcode_t;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////

    // renamed micro-op from dispatch
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [PHY_IDX-1:0] rs1_phy;
        logic               rs1_valid;
        logic [PHY_IDX-1:0] rs2_phy;
        logic               rs2_valid;
        op1_sel_t           op1_sel;
        op2_sel_t           op2_sel;
        fu_opcode_t         fu_opcode;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
    } uop_t;

    // one broadcast lane
    typedef struct packed {
        logic               valid;
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        logic [XLEN-1:0]    value;
    } cdb_t;

    // station to alu, operands already read
    typedef struct packed {
        logic [ROB_IDX-1:0] rob_id;
        logic [PHY_IDX-1:0] rd_phy;
        op1_sel_t           op1_sel;
        op2_sel_t           op2_sel;
        fu_opcode_t         fu_opcode;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    rs1_value;
        logic [XLEN-1:0]    rs2_value;
    } alu_issue_t;

endpackage
